// ==== hw/rv_fe_pkg.sv ====
// Shared sizes, instruction views and bus payloads for the RV32I front end
// Imported by every front end block and by the testbench
package rv_fe_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Data and address width
  localparam int XLEN = 32;
  // First fetch address after reset
  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;
  // Program image depth in words
  localparam int ROM_WORDS = 16;
  localparam int ROM_AW    = $clog2(ROM_WORDS);

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes the pre-decoder cares about
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // CSR access forms under OPC_SYSTEM
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // addi x0,x0,0
  localparam logic [31:0] INSN_NOP = 32'h0000_0013;

  // AXI4-Lite codes used on the fetch port
  localparam logic [2:0] AXI_PROT_INSN   = 3'b100;
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  //////////////////////////////
  // Instruction word
  //////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;

  // Branch offset is scattered around the register fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_j_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_b_t b;
    insn_j_t j;
  } insn_t;

  //////////////////////////////
  // Payloads
  //////////////////////////////

  // AXI4-Lite read address and read data
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [2:0]      prot;
  } axil_ar_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [1:0]      resp;
  } axil_r_t;

  // Fetched word paired with its address
  typedef struct packed {
    logic [XLEN-1:0] pc;
    insn_t           insn;
  } fetch_t;

  // Output stream toward decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    insn_t           insn;
    logic            taken;
    logic [11:0]     csr_addr;
  } pd_out_t;

endpackage

// ==== hw/pc_gen.sv ====
// Fetch address register for the front end
// Loads flush or redirect targets, otherwise steps one word per issued read
`timescale 1ns/10ps

module pc_gen
  import rv_fe_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            advance_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            flush_i,
  input  logic [XLEN-1:0] flush_pc_i,
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;

  //////////////////////////////
  // Address register
  //////////////////////////////

  // Flush beats redirect, redirect beats the sequential step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= {PC_INIT[XLEN-1:2], 2'b00};
    end else if (flush_i) begin
      pc_q <= {flush_pc_i[XLEN-1:2], 2'b00};
    end else if (redirect_i) begin
      pc_q <= {redirect_pc_i[XLEN-1:2], 2'b00};
    end else if (advance_i) begin
      // Word aligned step
      pc_q <= pc_q + XLEN'(4);
    end
  end

  assign pc_o = pc_q;

  // No compressed support so every fetch is word aligned
  pc_aligned_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pc_o[1:0] == 2'b00
  );

endmodule

// ==== hw/fetch_fsm.sv ====
// AXI4-Lite read master for instruction fetch
// One read in flight, response paired with its address and handed to the pre-decoder
`timescale 1ns/10ps

module fetch_fsm
  import rv_fe_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] pc_i,
  output logic            advance_o,
  input  logic            flush_i,
  input  logic            redirect_i,
  output logic            ar_valid_o,
  output axil_ar_t        ar_o,
  input  logic            ar_ready_i,
  input  logic            r_valid_i,
  input  axil_r_t         r_i,
  output logic            r_ready_o,
  output logic            fetch_valid_o,
  output fetch_t          fetch_o,
  input  logic            pd_ready_i
);

  typedef enum logic [1:0] {IDLE, ADDR, DATA} state_e;

  state_e          state_q, state_d;
  logic            drop_q, drop_d;
  logic [XLEN-1:0] addr_q;
  logic            kill;
  logic            ar_hs;
  logic            r_hs;

  // Any change of flow makes the read in flight stale
  assign kill = flush_i | redirect_i;

  //////////////////////////////
  // Bus side
  //////////////////////////////

  // Address comes straight from the generator
  assign ar_valid_o = (state_q == ADDR);
  assign ar_o.addr  = pc_i;
  assign ar_o.prot  = AXI_PROT_INSN;
  assign ar_hs      = ar_valid_o & ar_ready_i;
  assign advance_o  = ar_hs;

  // Stale words are swallowed without waiting on the pre-decoder
  assign r_ready_o = (state_q == DATA) & (drop_q | pd_ready_i);
  assign r_hs      = r_valid_i & r_ready_o;

  // Error responses turn into a NOP
  assign fetch_valid_o = (state_q == DATA) & r_valid_i & ~drop_q;
  assign fetch_o.pc    = addr_q;
  assign fetch_o.insn  = (r_i.resp == AXI_RESP_OKAY) ? r_i.data : INSN_NOP;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    drop_d  = drop_q;
    unique case (state_q)
      // Gap cycle so a redirect lands before the next address
      IDLE: state_d = ADDR;
      ADDR: begin
        if (ar_hs) begin
          state_d = DATA;
          // Address went out on the same cycle as a flush
          drop_d  = kill;
        end
      end
      DATA: begin
        if (kill) begin
          drop_d = 1'b1;
        end
        if (r_hs) begin
          state_d = IDLE;
          drop_d  = 1'b0;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      drop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      drop_q  <= drop_d;
    end
  end

  // Address of the read in flight
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= pc_i;
    end
  end

  // AR payload holds until accepted unless a flush moves the pc
  ar_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
  );

endmodule

// ==== hw/insn_rom.sv ====
// Read-only AXI4-Lite slave holding the program image
// Image comes from tests/program.hex, one response per accepted address
`timescale 1ns/10ps

module insn_rom
  import rv_fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ar_valid_i,
  input  axil_ar_t ar_i,
  output logic     ar_ready_o,
  output logic     r_valid_o,
  output axil_r_t  r_o,
  input  logic     r_ready_i
);

  logic [XLEN-1:0]   mem [ROM_WORDS];
  logic [ROM_AW-1:0] idx;
  logic              in_range;
  logic              ar_hs;
  logic              r_valid_q;
  axil_r_t           r_q;

  //////////////////////////////
  // Image
  //////////////////////////////

  initial begin
    $readmemh("tests/program.hex", mem);
  end

  // Word index and upper bits beyond the image
  assign idx      = ar_i.addr[ROM_AW+1:2];
  assign in_range = ~|ar_i.addr[XLEN-1:ROM_AW+2];

  //////////////////////////////
  // Read channel
  //////////////////////////////

  // No new address while a response is pending
  assign ar_ready_o = ~r_valid_q;
  assign ar_hs      = ar_valid_i & ar_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (ar_hs) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Out of range reads get SLVERR and a NOP
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      r_q.data <= in_range ? mem[idx] : INSN_NOP;
      r_q.resp <= in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_o       = r_q;

endmodule

// ==== hw/pre_decoder.sv ====
// Registered pre-decode stage between fetch and decode
// Predicts JAL and backward branches taken and holds the slot after a CSR write
`timescale 1ns/10ps

module pre_decoder
  import rv_fe_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_valid_i,
  input  fetch_t          fetch_i,
  output logic            pd_ready_o,
  input  logic            flush_i,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output logic            pd_valid_o,
  output pd_out_t         pd_o,
  input  logic            id_ready_i
);

  insn_t           insn;
  logic [XLEN-1:0] ext_j;
  logic [XLEN-1:0] ext_b;
  logic [XLEN-1:0] target;
  logic            is_jal;
  logic            is_branch;
  logic            taken;
  logic            csr_wr;
  logic            accept;
  logic            pd_valid_q;
  logic            redirect_q;
  logic            csr_hold_q;
  logic [XLEN-1:0] redirect_pc_q;
  pd_out_t         pd_q;

  assign insn = fetch_i.insn;

  //////////////////////////////
  // Static prediction
  //////////////////////////////

  // Rebuild offsets from the scattered immediate bits
  assign ext_j = {{(XLEN-20){insn.j.imm20}}, insn.j.imm19_12, insn.j.imm11,
                  insn.j.imm10_1, 1'b0};
  assign ext_b = {{(XLEN-12){insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5,
                  insn.b.imm4_1, 1'b0};

  assign is_jal    = (insn.r.opcode == OPC_JAL);
  assign is_branch = (insn.r.opcode == OPC_BRANCH);

  // Backward branch means negative offset
  assign taken  = is_jal | (is_branch & ext_b[XLEN-1]);
  assign target = fetch_i.pc + (is_jal ? ext_j : ext_b);

  //////////////////////////////
  // CSR write detect
  //////////////////////////////

  // Set and clear forms with a zero source only read the CSR
  always_comb begin
    csr_wr = 1'b0;
    if (insn.i.opcode == OPC_SYSTEM) begin
      case (insn.i.funct3)
        F3_CSRRW, F3_CSRRWI: csr_wr = 1'b1;
        F3_CSRRS, F3_CSRRC,
        F3_CSRRSI, F3_CSRRCI: csr_wr = |insn.i.rs1;
        default: csr_wr = 1'b0;
      endcase
    end
  end

  //////////////////////////////
  // Pipeline register
  //////////////////////////////

  // Room when empty or draining, never in the slot after a CSR write
  assign pd_ready_o = ~csr_hold_q & (~pd_valid_q | id_ready_i);
  assign accept     = fetch_valid_i & pd_ready_o & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_valid_q <= 1'b0;
      redirect_q <= 1'b0;
      csr_hold_q <= 1'b0;
    end else if (flush_i) begin
      pd_valid_q <= 1'b0;
      redirect_q <= 1'b0;
      csr_hold_q <= 1'b0;
    end else begin
      if (accept) begin
        pd_valid_q <= 1'b1;
      end else if (id_ready_i) begin
        pd_valid_q <= 1'b0;
      end
      // One strobe per instruction, on its first output cycle
      redirect_q <= accept & taken;
      csr_hold_q <= accept & csr_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pd_q.pc       <= fetch_i.pc;
      pd_q.insn     <= insn;
      pd_q.taken    <= taken;
      // CSR number sits in the I immediate
      pd_q.csr_addr <= insn.i.imm;
      redirect_pc_q <= target;
    end
  end

  assign pd_valid_o    = pd_valid_q;
  assign pd_o          = pd_q;
  assign redirect_o    = redirect_q;
  assign redirect_pc_o = redirect_pc_q;

  // Redirect only for a live taken output
  redirect_valid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    redirect_o |-> pd_valid_o && pd_o.taken
  );

  // Output holds under back-pressure
  pd_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    pd_valid_o && !id_ready_i |=> pd_valid_o && $stable(pd_o)
  );

endmodule

// ==== hw/rv_frontend.sv ====
// Front end top level for the RV32I core
// Address generator, fetch master, program ROM and pre-decoder in one block
`timescale 1ns/10ps

module rv_frontend
  import rv_fe_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic [XLEN-1:0] flush_pc_i,
  output logic            pd_valid_o,
  output pd_out_t         pd_o,
  input  logic            id_ready_i
);

  // Address generation
  logic [XLEN-1:0] pc;
  logic            advance;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  // Fetch port
  logic            ar_valid;
  axil_ar_t        ar;
  logic            ar_ready;
  logic            r_valid;
  axil_r_t         r;
  logic            r_ready;

  // Fetch to pre-decode
  logic            fetch_valid;
  fetch_t          fetch;
  logic            pd_ready;

  pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .advance_i     (advance),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .pc_o          (pc)
  );

  fetch_fsm u_fetch_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pc_i          (pc),
    .advance_o     (advance),
    .flush_i       (flush_i),
    .redirect_i    (redirect),
    .ar_valid_o    (ar_valid),
    .ar_o          (ar),
    .ar_ready_i    (ar_ready),
    .r_valid_i     (r_valid),
    .r_i           (r),
    .r_ready_o     (r_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch),
    .pd_ready_i    (pd_ready)
  );

  insn_rom u_insn_rom (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .r_ready_i  (r_ready)
  );

  pre_decoder u_pre_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid),
    .fetch_i       (fetch),
    .pd_ready_o    (pd_ready),
    .flush_i       (flush_i),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .pd_valid_o    (pd_valid_o),
    .pd_o          (pd_o),
    .id_ready_i    (id_ready_i)
  );

endmodule

// ==== tests/tb_rv_frontend.sv ====
// Testbench for the RV32I front end
// Follows the predicted fetch stream against a reference model of the static predictor
`timescale 1ns/10ps

module tb_rv_frontend
  import rv_fe_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int CHAIN_LEN     = 40;
  // Outputs over all tests: two chains plus the two flush runs
  localparam int TOTAL_OUTPUTS = 2 * CHAIN_LEN + 3 + 12;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            flush_i;
  logic [XLEN-1:0] flush_pc_i;
  logic            pd_valid_o;
  pd_out_t         pd_o;
  logic            id_ready_i;

  logic [31:0]     image [ROM_WORDS];
  pd_out_t         outputs [$];
  pd_out_t         exp_pd;
  pd_out_t         held_pd;
  logic [XLEN-1:0] exp_pc;
  logic [31:0]     lcg_state;
  logic            rand_ready;
  logic            held;
  int              hits [ROM_WORDS];
  int              taken_hits [ROM_WORDS];
  int              n_out;
  int              n_wait;
  int              n_err;
  int              n_checks;
  int              n_tests;
  int              err_mark;
  int              first_idx;

  rv_frontend UUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .flush_pc_i (flush_pc_i),
    .pd_valid_o (pd_valid_o),
    .pd_o       (pd_o),
    .id_ready_i (id_ready_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Words past the image come back as NOP
  function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] pc);
    if (pc[XLEN-1:2] < ROM_WORDS) begin
      return image[pc[5:2]];
    end
    return INSN_NOP;
  endfunction

  // JAL always, conditional branch only with a negative offset
  function automatic logic pred_taken(input logic [31:0] w);
    return (w[6:0] == OPC_JAL) || ((w[6:0] == OPC_BRANCH) && w[31]);
  endfunction

  function automatic logic [XLEN-1:0] next_pc(input logic [XLEN-1:0] pc,
                                              input logic [31:0] w);
    logic [XLEN-1:0] off_j;
    logic [XLEN-1:0] off_b;
    off_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    off_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (w[6:0] == OPC_JAL) begin
      return pc + off_j;
    end else if ((w[6:0] == OPC_BRANCH) && w[31]) begin
      return pc + off_b;
    end
    return pc + 32'd4;
  endfunction

  function automatic pd_out_t expect_pd(input logic [XLEN-1:0] pc);
    pd_out_t e;
    e.pc       = pc;
    e.insn     = fetch_word(pc);
    e.taken    = pred_taken(fetch_word(pc));
    // CSR number is the top twelve bits
    e.csr_addr = fetch_word(pc) >> 20;
    return e;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_pd(input pd_out_t got, input pd_out_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("MISMATCH at %0t: %s pc %h insn %h taken %b csr %h, expected %h %h %b %h",
               $time, what, got.pc, got.insn, got.taken, got.csr_addr,
               exp.pc, exp.insn, exp.taken, exp.csr_addr);
    end
  endtask

  task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("MISMATCH at %0t: %s pc %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic require(input bit cond, input string what);
    n_checks++;
    if (!cond) begin
      n_err++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  // Stored outputs against the reference chain from start
  task automatic check_chain(input int base, input int count, input logic [XLEN-1:0] start,
                             input string what);
    logic [XLEN-1:0] pc;
    pc = start;
    for (int i = 0; i < count; i++) begin
      check_pd(outputs[base + i], expect_pd(pc), what);
      pc = next_pc(pc, fetch_word(pc));
    end
  endtask

  task automatic wait_outputs(input int count);
    int target;
    target = n_out + count;
    while (n_out < target) begin
      @(posedge clk_i);
    end
  endtask

  // Flush for one cycle, the stream restarts at target
  task automatic flush_to(input logic [XLEN-1:0] target);
    @(posedge clk_i);
    flush_i    <= 1'b1;
    flush_pc_i <= target;
    exp_pc     = target;
    first_idx  = n_out;
    @(posedge clk_i);
    flush_i    <= 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    n_tests++;
    if (n_err == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, n_err - errs_before);
    end
  endtask

  //////////////////////////////
  // Ready pattern and monitor
  //////////////////////////////

  always @(posedge clk_i) begin
    if (rand_ready) begin
      lcg_state = lcg_next(lcg_state);
      id_ready_i <= lcg_state[30];
    end
  end

  // Negedge sampling, inputs only move on the rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      if (pd_valid_o !== 1'b0) begin
        n_err++;
        $display("Output valid was high during reset at %0t", $time);
      end
    end else begin
      if (held) begin
        if (pd_valid_o !== 1'b1) begin
          n_err++;
          $display("Output valid dropped while decode was not ready at %0t", $time);
        end
        check_pd(pd_o, held_pd, "output under back-pressure");
      end
      held    = pd_valid_o && !id_ready_i && !flush_i;
      held_pd = pd_o;
      if (held) begin
        n_wait++;
      end
      // Transfer happens on the coming edge
      if (pd_valid_o && id_ready_i && !flush_i) begin
        exp_pd = expect_pd(exp_pc);
        check_pd(pd_o, exp_pd, "accepted output");
        exp_pc = next_pc(exp_pc, exp_pd.insn);
        if (pd_o.pc[XLEN-1:2] < ROM_WORDS) begin
          hits[pd_o.pc[5:2]]++;
          if (pd_o.taken) begin
            taken_hits[pd_o.pc[5:2]]++;
          end
        end
        outputs.push_back(pd_o);
        n_out++;
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    flush_pc_i = '0;
    id_ready_i = 1'b1;
    rand_ready = 1'b0;
    lcg_state  = 32'he5a6af2f;
    exp_pc     = PC_INIT;
    held       = 1'b0;
    n_out      = 0;
    n_wait     = 0;
    n_err      = 0;
    n_checks   = 0;
    n_tests    = 0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      hits[i]       = 0;
      taken_hits[i] = 0;
    end
    $readmemh("tests/program.hex", image);
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    err_mark = n_err;
    wait_outputs(1);
    check_pc(outputs[0].pc, PC_INIT, "first output after reset");
    report_test(1, "first output after reset", err_mark);

    // Full ready, chain checked by the monitor
    err_mark = n_err;
    wait_outputs(CHAIN_LEN - 1);
    report_test(2, "sequential and predicted stream", err_mark);

    err_mark = n_err;
    require(taken_hits[7] > 0, "forward JAL was not predicted taken");
    require(taken_hits[11] > 0, "backward JAL was not predicted taken");
    require(taken_hits[14] > 0, "backward branch was not predicted taken");
    require(hits[3] > 0 && taken_hits[3] == 0, "forward branch was predicted taken");
    require(hits[4] > 0, "forward branch fall through never showed up");
    report_test(3, "static branch prediction", err_mark);

    // CSR writes at words 1, 5 and 9, read only CSRRS at word 2
    err_mark = n_err;
    require(hits[1] > 0 && hits[5] > 0 && hits[9] > 0, "a CSR write never showed up");
    require(hits[2] > 0, "the read only CSR access never showed up");
    check_chain(0, CHAIN_LEN, PC_INIT, "stream order");
    report_test(4, "CSR accesses and ordering", err_mark);

    // Replay from reset address with random ready
    err_mark = n_err;
    @(posedge clk_i);
    rand_ready <= 1'b1;
    flush_to(PC_INIT);
    wait_outputs(CHAIN_LEN);
    check_chain(first_idx, CHAIN_LEN, PC_INIT, "replay under back-pressure");
    require(n_wait > 0, "random ready never stalled an output");
    report_test(5, "random back-pressure", err_mark);

    // Last image word, then two reads past the image
    err_mark = n_err;
    flush_to(32'h0000_003c);
    wait_outputs(3);
    check_pc(outputs[first_idx].pc, 32'h0000_003c, "first output after flush");
    flush_to(32'h0000_0024);
    wait_outputs(12);
    check_pc(outputs[first_idx].pc, 32'h0000_0024, "first output after flush");
    report_test(6, "flush to a new address", err_mark);

    $display("tests %0d, outputs %0d, checks %0d, errors %0d", n_tests, n_out, n_checks, n_err);
    if (n_err == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Generous bound of forty cycles per expected output
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 40 * TOTAL_OUTPUTS));
    $display("Watchdog expired with %0d of %0d outputs seen", n_out, TOTAL_OUTPUTS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== tests/program.hex ====
// One 32-bit RV32I instruction word per line, word 0 at address 0x00
00500093
34009073
30002173
00000463
00100193
3411D073
00200213
0140006F
00300293
3002A073
00400313
FD5FF06F
00500393
FFF08093
FE0094E3
00000013

// ==== build.f ====
hw/rv_fe_pkg.sv
hw/pc_gen.sv
hw/fetch_fsm.sv
hw/insn_rom.sv
hw/pre_decoder.sv
hw/rv_frontend.sv
tests/tb_rv_frontend.sv
